// ==== hdl/dispatch_defs.svh ====
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// architectural registers
`define DISP_NUM_REGS 32
`define DISP_REG_W 5

// operand, immediate and pc width
`define DISP_DATA_W 32

// reorder-buffer tags
`define DISP_ROB_DEPTH 8
`define DISP_TAG_W 3

// entries per issue buffer
`define DISP_BUF_DEPTH 4

// cycles spent in flush before dispatch resumes
`define DISP_FLUSH_CYCLES 2

`endif

// ==== hdl/dispatch_pkg.sv ====
`include "dispatch_defs.svh"

package dispatch_pkg;

    // instruction class as seen by dispatch
    typedef enum logic [2:0] {
        op_nop    = 3'd0,
        op_alu    = 3'd1,
        op_branch = 3'd2,
        op_load   = 3'd3,
        op_store  = 3'd4
    } op_class_t;

    // source operand, either a value or a pending producer tag
    typedef struct packed {
        logic                     busy;
        logic [`DISP_TAG_W-1:0]   tag;
        logic [`DISP_DATA_W-1:0]  value;
    } operand_t;

    // reservation-station entry
    typedef struct packed {
        op_class_t                op_class;
        operand_t                 src1;
        operand_t                 src2;
        logic [`DISP_DATA_W-1:0]  pc;
        logic [`DISP_DATA_W-1:0]  imm;
        logic [`DISP_TAG_W-1:0]   rob_tag;
    } rs_entry_t;

    // load/store buffer entry, no pc needed here
    typedef struct packed {
        op_class_t                op_class;
        operand_t                 src1;
        operand_t                 src2;
        logic [`DISP_DATA_W-1:0]  imm;
        logic [`DISP_TAG_W-1:0]   rob_tag;
    } lsb_entry_t;

endpackage

// ==== hdl/reg_lookup_if.sv ====
`include "dispatch_defs.svh"

interface reg_lookup_if;

    // source lookup
    logic [`DISP_REG_W-1:0]  rs1;
    logic [`DISP_REG_W-1:0]  rs2;
    dispatch_pkg::operand_t  opnd1;
    dispatch_pkg::operand_t  opnd2;

    // destination rename
    logic                    rename_en;
    logic [`DISP_REG_W-1:0]  rename_rd;
    logic [`DISP_TAG_W-1:0]  rename_tag;

    modport ctrl (
        output rs1, rs2, rename_en, rename_rd, rename_tag,
        input  opnd1, opnd2
    );

    modport status (
        input  rs1, rs2, rename_en, rename_rd, rename_tag,
        output opnd1, opnd2
    );

endinterface

// ==== hdl/reg_status_file.sv ====
`include "dispatch_defs.svh"

module reg_status_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rdy,
    input  logic                     flush_clear,
    reg_lookup_if.status             lk,
    input  logic                     cdb_valid,
    input  logic [`DISP_TAG_W-1:0]   cdb_tag,
    input  logic [`DISP_DATA_W-1:0]  cdb_value
);

    logic [`DISP_DATA_W-1:0]  value_q [`DISP_NUM_REGS];
    logic [`DISP_TAG_W-1:0]   tag_q [`DISP_NUM_REGS];
    logic [`DISP_NUM_REGS-1:0] busy_q;

    // current view of one register, with cdb bypass
    function automatic dispatch_pkg::operand_t read_operand(
        input logic [`DISP_REG_W-1:0] idx
    );
        dispatch_pkg::operand_t opnd;
        opnd.busy  = busy_q[idx];
        opnd.tag   = tag_q[idx];
        opnd.value = value_q[idx];
        if (idx == '0) begin
            opnd = '0;
        end else if (opnd.busy && cdb_valid && opnd.tag == cdb_tag) begin
            opnd.busy  = 1'b0;
            opnd.value = cdb_value;
        end
        // tag only means something while busy
        if (!opnd.busy) begin
            opnd.tag = '0;
        end
        return opnd;
    endfunction

    always_comb begin
        lk.opnd1 = read_operand(lk.rs1);
        lk.opnd2 = read_operand(lk.rs2);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= '0;
            for (int i = 0; i < `DISP_NUM_REGS; i++) begin
                value_q[i] <= '0;
                tag_q[i]   <= '0;
            end
        end else if (rdy) begin
            if (flush_clear) begin
                busy_q <= '0;
            end else begin
                for (int i = 0; i < `DISP_NUM_REGS; i++) begin
                    if (cdb_valid && busy_q[i] && tag_q[i] == cdb_tag) begin
                        value_q[i] <= cdb_value;
                        busy_q[i]  <= 1'b0;
                    end
                    // a rename in the same cycle wins over writeback
                    if (lk.rename_en && int'(lk.rename_rd) == i) begin
                        busy_q[i] <= 1'b1;
                        tag_q[i]  <= lk.rename_tag;
                    end
                end
            end
        end
    end

    // x0 must never pick up a producer
    x0_never_busy: assert property (@(posedge clk) disable iff (rst) !busy_q[0]);

endmodule

// ==== hdl/rob_tag_alloc.sv ====
`include "dispatch_defs.svh"

module rob_tag_alloc (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,
    input  logic                    flush_clear,
    input  logic                    alloc,
    input  logic                    commit_valid,
    output logic [`DISP_TAG_W-1:0]  alloc_tag,
    output logic                    rob_full,
    output logic                    rob_empty
);

    localparam int cnt_w = $clog2(`DISP_ROB_DEPTH + 1);

    logic [`DISP_TAG_W-1:0] head_q;
    logic [`DISP_TAG_W-1:0] tail_q;
    logic [cnt_w-1:0]       count_q;
    logic                   do_alloc;
    logic                   do_free;

    function automatic logic [`DISP_TAG_W-1:0] next_tag(input logic [`DISP_TAG_W-1:0] t);
        return (int'(t) == `DISP_ROB_DEPTH - 1) ? '0 : t + 1'b1;
    endfunction

    assign alloc_tag = tail_q;
    assign rob_full  = (int'(count_q) == `DISP_ROB_DEPTH);
    assign rob_empty = (count_q == '0);

    assign do_alloc = alloc && !rob_full;
    // commit on an empty allocator is dropped
    assign do_free  = commit_valid && !rob_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (rdy) begin
            if (flush_clear) begin
                head_q  <= '0;
                tail_q  <= '0;
                count_q <= '0;
            end else begin
                if (do_alloc) tail_q <= next_tag(tail_q);
                if (do_free) head_q <= next_tag(head_q);
                if (do_alloc && !do_free) count_q <= count_q + 1'b1;
                else if (do_free && !do_alloc) count_q <= count_q - 1'b1;
            end
        end
    end

    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !rob_full);
    no_commit_when_empty: assert property (@(posedge clk) disable iff (rst)
        (rdy && commit_valid) |-> !rob_empty);
    // oldest tag plus outstanding count lands on the next free tag
    head_tail_consistent: assert property (@(posedge clk) disable iff (rst)
        tail_q == head_q + count_q[`DISP_TAG_W-1:0]);

endmodule

// ==== hdl/dispatch_ctrl.sv ====
`include "dispatch_defs.svh"

module dispatch_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rdy,
    input  logic                     flush,
    input  logic                     inst_valid,
    input  dispatch_pkg::op_class_t  inst_class,
    input  logic [`DISP_REG_W-1:0]   inst_rd,
    input  logic [`DISP_REG_W-1:0]   inst_rs1,
    input  logic [`DISP_REG_W-1:0]   inst_rs2,
    input  logic [`DISP_DATA_W-1:0]  inst_imm,
    input  logic [`DISP_DATA_W-1:0]  inst_pc,
    output logic                     inst_ready,
    reg_lookup_if.ctrl               lk,
    output logic                     alloc,
    input  logic [`DISP_TAG_W-1:0]   alloc_tag,
    input  logic                     rob_full,
    output logic                     rs_push,
    output dispatch_pkg::rs_entry_t  rs_push_entry,
    input  logic                     rs_full,
    output logic                     lsb_push,
    output dispatch_pkg::lsb_entry_t lsb_push_entry,
    input  logic                     lsb_full,
    output logic                     flush_clear
);

    localparam int cnt_w = $clog2(`DISP_FLUSH_CYCLES + 1);

    typedef enum logic {st_run, st_flush} state_t;

    state_t           state_q;
    logic [cnt_w-1:0] flush_cnt_q;
    logic             to_rs;
    logic             to_lsb;
    logic             has_space;
    logic             xfer;

    assign to_rs  = (inst_class == dispatch_pkg::op_alu) ||
                    (inst_class == dispatch_pkg::op_branch);
    assign to_lsb = (inst_class == dispatch_pkg::op_load) ||
                    (inst_class == dispatch_pkg::op_store);

    // nop needs nothing, everything else needs a slot and a tag
    assign has_space = to_rs  ? (!rs_full && !rob_full)  :
                       to_lsb ? (!lsb_full && !rob_full) :
                       (inst_class == dispatch_pkg::op_nop);

    assign inst_ready = (state_q == st_run) && !flush && has_space;
    assign xfer       = inst_valid && inst_ready && rdy;

    assign alloc    = xfer && (to_rs || to_lsb);
    assign rs_push  = xfer && to_rs;
    assign lsb_push = xfer && to_lsb;

    assign flush_clear = flush;

    assign lk.rs1        = inst_rs1;
    assign lk.rs2        = inst_rs2;
    assign lk.rename_en  = alloc && (inst_rd != '0);
    assign lk.rename_rd  = inst_rd;
    assign lk.rename_tag = alloc_tag;

    always_comb begin
        rs_push_entry.op_class = inst_class;
        rs_push_entry.src1     = lk.opnd1;
        rs_push_entry.src2     = lk.opnd2;
        rs_push_entry.pc       = inst_pc;
        rs_push_entry.imm      = inst_imm;
        rs_push_entry.rob_tag  = alloc_tag;

        lsb_push_entry.op_class = inst_class;
        lsb_push_entry.src1     = lk.opnd1;
        lsb_push_entry.src2     = lk.opnd2;
        lsb_push_entry.imm      = inst_imm;
        lsb_push_entry.rob_tag  = alloc_tag;
    end

    // reset lands in flush with an expired counter, so run follows next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= st_flush;
            flush_cnt_q <= '0;
        end else if (rdy) begin
            if (flush) begin
                state_q     <= st_flush;
                flush_cnt_q <= cnt_w'(`DISP_FLUSH_CYCLES - 1);
            end else if (state_q == st_flush) begin
                if (flush_cnt_q == '0) state_q <= st_run;
                else flush_cnt_q <= flush_cnt_q - 1'b1;
            end
        end
    end

    // an unknown class would never see inst_ready
    known_class: assert property (@(posedge clk) disable iff (rst)
        (rdy && inst_valid) |-> (to_rs || to_lsb || inst_class == dispatch_pkg::op_nop));

endmodule

// ==== hdl/issue_buffer.sv ====
`include "dispatch_defs.svh"

module issue_buffer #(
    parameter type entry_t = dispatch_pkg::rs_entry_t,
    parameter int  DEPTH   = `DISP_BUF_DEPTH
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   flush_clear,
    input  logic   push,
    input  entry_t push_entry,
    output logic   full,
    input  logic   pop,
    output logic   valid,
    output entry_t head_entry
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];
    logic [ptr_w-1:0] rd_ptr_q;
    logic [ptr_w-1:0] wr_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (int'(p) == DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    assign full  = (int'(count_q) == DEPTH);
    assign valid = (count_q != '0);

    // show-ahead: head is always on the output
    assign head_entry = mem[rd_ptr_q];

    assign do_push = rdy && !flush_clear && push && !full;
    assign do_pop  = rdy && !flush_clear && pop && valid;

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr_q] <= push_entry;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (rdy) begin
            if (flush_clear) begin
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
                if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
                if (do_push && !do_pop) count_q <= count_q + 1'b1;
                else if (do_pop && !do_push) count_q <= count_q - 1'b1;
            end
        end
    end

    // controller must hold back on a full buffer
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        (rdy && push) |-> !full);

endmodule

// ==== hdl/dispatch_top.sv ====
`include "dispatch_defs.svh"

module dispatch_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rdy,
    input  logic                      inst_valid,
    input  dispatch_pkg::op_class_t   inst_class,
    input  logic [`DISP_REG_W-1:0]    inst_rd,
    input  logic [`DISP_REG_W-1:0]    inst_rs1,
    input  logic [`DISP_REG_W-1:0]    inst_rs2,
    input  logic [`DISP_DATA_W-1:0]   inst_imm,
    input  logic [`DISP_DATA_W-1:0]   inst_pc,
    output logic                      inst_ready,
    input  logic                      cdb_valid,
    input  logic [`DISP_TAG_W-1:0]    cdb_tag,
    input  logic [`DISP_DATA_W-1:0]   cdb_value,
    input  logic                      commit_valid,
    input  logic                      flush,
    input  logic                      rs_pop,
    output logic                      rs_valid,
    output dispatch_pkg::rs_entry_t   rs_entry,
    input  logic                      lsb_pop,
    output logic                      lsb_valid,
    output dispatch_pkg::lsb_entry_t  lsb_entry
);

    reg_lookup_if lk ();

    logic                     alloc;
    logic [`DISP_TAG_W-1:0]   alloc_tag;
    logic                     rob_full;
    logic                     flush_clear;
    logic                     rs_push;
    logic                     rs_full;
    logic                     lsb_push;
    logic                     lsb_full;
    dispatch_pkg::rs_entry_t  rs_push_entry;
    dispatch_pkg::lsb_entry_t lsb_push_entry;

    dispatch_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .rdy            (rdy),
        .flush          (flush),
        .inst_valid     (inst_valid),
        .inst_class     (inst_class),
        .inst_rd        (inst_rd),
        .inst_rs1       (inst_rs1),
        .inst_rs2       (inst_rs2),
        .inst_imm       (inst_imm),
        .inst_pc        (inst_pc),
        .inst_ready     (inst_ready),
        .lk             (lk.ctrl),
        .alloc          (alloc),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .rs_push        (rs_push),
        .rs_push_entry  (rs_push_entry),
        .rs_full        (rs_full),
        .lsb_push       (lsb_push),
        .lsb_push_entry (lsb_push_entry),
        .lsb_full       (lsb_full),
        .flush_clear    (flush_clear)
    );

    reg_status_file i_regs (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush_clear (flush_clear),
        .lk          (lk.status),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

    // empty flag is only needed inside the allocator
    rob_tag_alloc i_tags (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .flush_clear  (flush_clear),
        .alloc        (alloc),
        .commit_valid (commit_valid),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .rob_empty    ()
    );

    issue_buffer #(
        .entry_t (dispatch_pkg::rs_entry_t),
        .DEPTH   (`DISP_BUF_DEPTH)
    ) i_rs_buf (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush_clear (flush_clear),
        .push        (rs_push),
        .push_entry  (rs_push_entry),
        .full        (rs_full),
        .pop         (rs_pop),
        .valid       (rs_valid),
        .head_entry  (rs_entry)
    );

    issue_buffer #(
        .entry_t (dispatch_pkg::lsb_entry_t),
        .DEPTH   (`DISP_BUF_DEPTH)
    ) i_lsb_buf (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush_clear (flush_clear),
        .push        (lsb_push),
        .push_entry  (lsb_push_entry),
        .full        (lsb_full),
        .pop         (lsb_pop),
        .valid       (lsb_valid),
        .head_entry  (lsb_entry)
    );

endmodule

// ==== dv/dispatch_checker.sv ====
`include "dispatch_defs.svh"

module dispatch_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rdy,
    input  logic                      flush,
    input  logic                      inst_valid,
    input  logic                      inst_ready,
    input  logic                      exp_valid,
    input  logic [1:0]                exp_route,
    input  dispatch_pkg::rs_entry_t   exp_rs,
    input  dispatch_pkg::lsb_entry_t  exp_lsb,
    input  logic                      expect_stall,
    input  logic [8*16-1:0]           test_name,
    input  logic                      rs_valid,
    input  logic                      rs_pop,
    input  dispatch_pkg::rs_entry_t   rs_entry,
    input  logic                      lsb_valid,
    input  logic                      lsb_pop,
    input  dispatch_pkg::lsb_entry_t  lsb_entry,
    output int                        errors,
    output int                        pending
);
    timeunit 1ns;
    timeprecision 1ps;

    dispatch_pkg::rs_entry_t  rs_q [$];
    dispatch_pkg::lsb_entry_t lsb_q [$];
    dispatch_pkg::rs_entry_t  rs_exp;
    dispatch_pkg::lsb_entry_t lsb_exp;
    logic                     check_empty;

    task automatic compare_field(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %0s %0s: expected %h actual %h", test_name, field, exp, act);
            errors++;
        end
    endtask

    task automatic compare_operands(input string side, input dispatch_pkg::operand_t e1,
                                    input dispatch_pkg::operand_t a1,
                                    input dispatch_pkg::operand_t e2,
                                    input dispatch_pkg::operand_t a2);
        compare_field({side, ".src1.busy"}, 32'(e1.busy), 32'(a1.busy));
        compare_field({side, ".src1.tag"}, 32'(e1.tag), 32'(a1.tag));
        compare_field({side, ".src1.value"}, e1.value, a1.value);
        compare_field({side, ".src2.busy"}, 32'(e2.busy), 32'(a2.busy));
        compare_field({side, ".src2.tag"}, 32'(e2.tag), 32'(a2.tag));
        compare_field({side, ".src2.value"}, e2.value, a2.value);
    endtask

    initial begin
        errors      = 0;
        pending     = 0;
        check_empty = 1'b0;
    end

    // nothing may show up while reset is held
    always @(negedge clk) begin
        if (rst && (rs_valid || lsb_valid || inst_ready)) begin
            $display("Error: outputs not low during reset in %0s", test_name);
            errors++;
        end
    end

    always @(posedge clk) begin
        if (!rst && rdy) begin
            if (check_empty) begin
                if (rs_valid || lsb_valid) begin
                    $display("Error: entries still present after flush in %0s", test_name);
                    errors++;
                end
                check_empty = 1'b0;
            end
            if (flush) begin
                rs_q.delete();
                lsb_q.delete();
                check_empty = 1'b1;
            end else begin
                if (expect_stall && inst_ready) begin
                    compare_field("inst_ready", 32'd0, 32'd1);
                end
                if (rs_valid && rs_pop) begin
                    if (rs_q.size() == 0) begin
                        $display("Error: unexpected rs entry popped in %0s", test_name);
                        errors++;
                    end else begin
                        rs_exp = rs_q.pop_front();
                        compare_field("rs.class", 32'(rs_exp.op_class), 32'(rs_entry.op_class));
                        compare_operands("rs", rs_exp.src1, rs_entry.src1,
                                         rs_exp.src2, rs_entry.src2);
                        compare_field("rs.pc", rs_exp.pc, rs_entry.pc);
                        compare_field("rs.imm", rs_exp.imm, rs_entry.imm);
                        compare_field("rs.tag", 32'(rs_exp.rob_tag), 32'(rs_entry.rob_tag));
                    end
                end
                if (lsb_valid && lsb_pop) begin
                    if (lsb_q.size() == 0) begin
                        $display("Error: unexpected lsb entry popped in %0s", test_name);
                        errors++;
                    end else begin
                        lsb_exp = lsb_q.pop_front();
                        compare_field("lsb.class", 32'(lsb_exp.op_class),
                                      32'(lsb_entry.op_class));
                        compare_operands("lsb", lsb_exp.src1, lsb_entry.src1,
                                         lsb_exp.src2, lsb_entry.src2);
                        compare_field("lsb.imm", lsb_exp.imm, lsb_entry.imm);
                        compare_field("lsb.tag", 32'(lsb_exp.rob_tag),
                                      32'(lsb_entry.rob_tag));
                    end
                end
                // route 0 is a nop, nothing expected anywhere
                if (inst_valid && inst_ready && exp_valid) begin
                    if (exp_route == 2'd1) rs_q.push_back(exp_rs);
                    if (exp_route == 2'd2) lsb_q.push_back(exp_lsb);
                end
            end
        end
        pending = rs_q.size() + lsb_q.size();
    end

endmodule

// ==== dv/dispatch_tb.sv ====
`include "dispatch_defs.svh"

module dispatch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst;
    logic rdy;
    logic inst_valid;
    dispatch_pkg::op_class_t inst_class;
    logic [`DISP_REG_W-1:0] inst_rd;
    logic [`DISP_REG_W-1:0] inst_rs1;
    logic [`DISP_REG_W-1:0] inst_rs2;
    logic [`DISP_DATA_W-1:0] inst_imm;
    logic [`DISP_DATA_W-1:0] inst_pc;
    logic inst_ready;
    logic cdb_valid;
    logic [`DISP_TAG_W-1:0] cdb_tag;
    logic [`DISP_DATA_W-1:0] cdb_value;
    logic commit_valid;
    logic flush;
    logic rs_pop;
    logic rs_valid;
    dispatch_pkg::rs_entry_t rs_entry;
    logic lsb_pop;
    logic lsb_valid;
    dispatch_pkg::lsb_entry_t lsb_entry;

    logic exp_valid;
    logic [1:0] exp_route;
    dispatch_pkg::rs_entry_t exp_rs;
    dispatch_pkg::lsb_entry_t exp_lsb;
    logic expect_stall;
    logic [8*16-1:0] test_name;
    int errors;
    int pending;

    logic rs_en;
    logic lsb_en;
    logic rs_take;
    logic lsb_take;
    int unsigned lcg_state;
    int limit_cycles;
    int fd;
    int n_records;
    int block_cycles;
    logic block_rs_en;
    logic block_lsb_en;
    logic block_commit;
    logic wb_pending;
    logic [31:0] f [14];
    string line;
    byte kind;

    dispatch_top i_dut (.*);

    dispatch_checker i_chk (.*);

    always #10 clk = ~clk;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // pops paced at random while their route is enabled
    always begin
        @(posedge clk);
        lcg_state = lcg_next(lcg_state);
        rs_take   = rs_en && lcg_state[16];
        lsb_take  = lsb_en && lcg_state[20];
        #2;
        rs_pop  = rs_take;
        lsb_pop = lsb_take;
    end

    task automatic drive_instruction();
        inst_valid = 1'b1;
        inst_class = dispatch_pkg::op_class_t'(f[0][2:0]);
        inst_rd    = f[1][`DISP_REG_W-1:0];
        inst_rs1   = f[2][`DISP_REG_W-1:0];
        inst_rs2   = f[3][`DISP_REG_W-1:0];
        inst_imm   = f[4];
        inst_pc    = f[5];
        exp_route  = f[6][1:0];
        exp_rs     = '{dispatch_pkg::op_class_t'(f[0][2:0]),
                       '{f[8][0], f[9][`DISP_TAG_W-1:0], f[10]},
                       '{f[11][0], f[12][`DISP_TAG_W-1:0], f[13]},
                       f[5], f[4], f[7][`DISP_TAG_W-1:0]};
        exp_lsb    = '{exp_rs.op_class, exp_rs.src1, exp_rs.src2, f[4], exp_rs.rob_tag};
        exp_valid  = 1'b1;
        cdb_valid  = wb_pending;
        if (block_cycles > 0) begin
            expect_stall = 1'b1;
            repeat (block_cycles) @(posedge clk);
            #2;
            expect_stall = 1'b0;
            rs_en        = block_rs_en;
            lsb_en       = block_lsb_en;
            commit_valid = block_commit;
            block_cycles = 0;
        end
        forever begin
            @(posedge clk);
            if (inst_valid && inst_ready && rdy) break;
            #2;
            commit_valid = 1'b0;
        end
        #2;
        inst_valid   = 1'b0;
        exp_valid    = 1'b0;
        cdb_valid    = 1'b0;
        commit_valid = 1'b0;
        wb_pending   = 1'b0;
    endtask

    task automatic pulse_one(input int which);
        if (which == 0) cdb_valid = 1'b1;
        if (which == 1) commit_valid = 1'b1;
        if (which == 2) flush = 1'b1;
        @(posedge clk);
        #2;
        cdb_valid    = 1'b0;
        commit_valid = 1'b0;
        flush        = 1'b0;
    endtask

    function automatic logic is_record(input string s);
        return s.len() > 0 && s.getc(0) != "#" && s.getc(0) != "\n";
    endfunction

    initial begin
        watchdog();
    end

    task automatic watchdog();
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d cycles in %0s", limit_cycles, test_name);
        $display("TEST FAILED");
        $finish;
    endtask

    initial begin
        clk = 0;
        rst = 1;
        rdy = 1;
        inst_valid = 0;
        inst_class = dispatch_pkg::op_nop;
        {inst_rd, inst_rs1, inst_rs2, inst_imm, inst_pc} = '0;
        {cdb_valid, cdb_tag, cdb_value, commit_valid, flush} = '0;
        {rs_pop, lsb_pop, exp_valid, exp_route, expect_stall} = '0;
        exp_rs = '0;
        exp_lsb = '0;
        test_name = "reset";
        rs_en = 1;
        lsb_en = 1;
        lcg_state = 24;
        limit_cycles = 0;
        block_cycles = 0;
        wb_pending = 0;
        n_records = 0;
        fd = $fopen("dv/dispatch_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            $display("TEST FAILED");
            $finish;
        end else begin
            while ($fgets(line, fd)) begin
                if (is_record(line)) n_records++;
            end
            $fclose(fd);
            limit_cycles = n_records * 40 + 2000;
            repeat (10) @(posedge clk);
            #2;
            rst = 0;
            fd = $fopen("dv/dispatch_patterns.txt", "r");
            while ($fgets(line, fd)) begin
                if (is_record(line)) begin
                    kind = line.getc(0);
                    case (kind)
                        "T": void'($sscanf(line, "T %s", test_name));
                        "W": begin
                            void'($sscanf(line, "W %h %h", cdb_tag, cdb_value));
                            pulse_one(0);
                        end
                        "Y": begin
                            void'($sscanf(line, "Y %h %h", cdb_tag, cdb_value));
                            wb_pending = 1'b1;
                        end
                        "C": pulse_one(1);
                        "F": pulse_one(2);
                        "D": begin
                            wait (pending == 0);
                            @(posedge clk);
                            #2;
                        end
                        "S": void'($sscanf(line, "S %h %h", rs_en, lsb_en));
                        "B": void'($sscanf(line, "B %d %h %h %h", block_cycles,
                                           block_rs_en, block_lsb_en, block_commit));
                        "I": begin
                            void'($sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                          f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                          f[7], f[8], f[9], f[10], f[11], f[12], f[13]));
                            drive_instruction();
                        end
                        default: $display("skipping unknown record %0s", line);
                    endcase
                end
            end
            $fclose(fd);
            rs_en = 1;
            lsb_en = 1;
            wait (pending == 0);
            repeat (5) @(posedge clk);
            $display("records %0d, errors %0d", n_records, errors);
            if (errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/dispatch_pkg.sv
hdl/reg_lookup_if.sv
hdl/reg_status_file.sv
hdl/rob_tag_alloc.sv
hdl/dispatch_ctrl.sv
hdl/issue_buffer.sv
hdl/dispatch_top.sv
dv/dispatch_checker.sv
dv/dispatch_tb.sv

// ==== dv/dispatch_patterns.txt ====
# T name | W tag value | Y tag value (cdb with next I) | C | F | D (drain) | S rs_en lsb_en
# B cycles rs_en lsb_en commit | I cls rd rs1 rs2 imm pc route tag b1 t1 v1 b2 t2 v2
T routing
I 1 01 00 00 00000011 00001000 1 0 0 0 00000000 0 0 00000000
I 3 02 00 00 00000020 00001004 2 1 0 0 00000000 0 0 00000000
I 0 00 00 00 00000000 00001008 0 0 0 0 00000000 0 0 00000000
I 4 00 01 02 00000024 0000100c 2 2 1 0 00000000 1 1 00000000
I 2 00 00 00 00000040 00001010 1 3 0 0 00000000 0 0 00000000
T deps
W 0 000000aa
I 1 03 01 02 00000000 00001014 1 4 0 0 000000aa 1 1 00000000
Y 1 000000bb
I 1 04 02 00 00000005 00001018 1 5 0 0 000000bb 0 0 00000000
Y 4 000000cc
I 1 03 03 00 00000000 0000101c 1 6 0 0 000000cc 0 0 00000000
I 3 05 03 00 00000008 00001020 2 7 1 6 000000cc 0 0 00000000
T tags
B 4 1 1 1
I 1 06 00 00 00000000 00001024 1 0 0 0 00000000 0 0 00000000
C
C
C
C
C
C
C
T backpress
D
S 0 1
I 1 07 00 00 00000001 00002000 1 1 0 0 00000000 0 0 00000000
I 3 08 07 00 00000002 00002004 2 2 1 1 00000000 0 0 00000000
I 2 00 01 02 00000003 00002008 1 3 0 0 000000aa 0 0 000000bb
I 1 09 00 00 00000004 0000200c 1 4 0 0 00000000 0 0 00000000
I 4 00 09 08 00000005 00002010 2 5 1 4 00000000 1 2 00000000
I 1 0a 00 00 00000006 00002014 1 6 0 0 00000000 0 0 00000000
B 3 1 1 0
I 1 0b 0a 00 00000007 00002018 1 7 1 6 00000000 0 0 00000000
C
C
C
C
C
C
C
C
T flush
S 0 0
I 1 0c 00 00 00000000 00003000 1 0 0 0 00000000 0 0 00000000
I 3 0d 0c 00 00000000 00003004 2 1 1 0 00000000 0 0 00000000
F
B 2 1 1 0
I 1 0e 03 0c 00000010 00003008 1 0 0 0 000000cc 0 0 00000000
I 4 00 01 05 00000014 0000300c 2 1 0 0 000000aa 0 0 00000000
D
